// File: source/mips_pkg.sv
package mips_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		R_TYPE = 6'h00,
		ADDI   = 6'h08,
		ANDI   = 6'h0c,
		ORI    = 6'h0d,
		XORI   = 6'h0e,
		LUI    = 6'h0f,
		LW     = 6'h23,
		SW     = 6'h2b
	} op_t;

	// funct field of R-type, instr[5:0]
	typedef enum logic [5:0] {
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	// destination field select
	typedef enum logic {
		DST_RD,
		DST_RT
	} reg_dst_t;

	// operand source in E
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_M,
		FWD_W
	} fwd_sel_t;

endpackage

// File: source/ctrl_if.sv
`timescale 1ns/10ps

interface ctrl_if;
	import mips_pkg::*;

	// execute stage
	alu_op_t           alu_op_e;
	logic              alu_imm_sel_e;
	logic              sign_ext_e;
	logic [REG_AW-1:0] dst_e;

	// memory stage
	logic              mem_read_m;
	logic              mem_write_m;

	// writeback stage
	logic              reg_write_w;
	logic              mem_to_reg_w;
	logic [REG_AW-1:0] dst_w;

	modport decoder (
		output alu_op_e, alu_imm_sel_e, sign_ext_e, dst_e,
		output mem_read_m, mem_write_m,
		output reg_write_w, mem_to_reg_w, dst_w
	);

	// dst_e is watched by the hazard unit, not the datapath
	modport datapath (
		input alu_op_e, alu_imm_sel_e, sign_ext_e,
		input mem_read_m, mem_write_m,
		input reg_write_w, mem_to_reg_w, dst_w
	);

endinterface

// File: source/alu_decoder.sv
`timescale 1ns/10ps

module alu_decoder (
	input  mips_pkg::op_t    op,
	input  mips_pkg::funct_t funct,
	output mips_pkg::alu_op_t alu_op,
	output logic             known
);
	import mips_pkg::*;

	always_comb begin
		alu_op = ALU_ADD;
		known  = 1'b1;
		case (op)
			R_TYPE: begin
				case (funct)
					ADDU:    alu_op = ALU_ADD;
					SUBU:    alu_op = ALU_SUB;
					AND:     alu_op = ALU_AND;
					OR:      alu_op = ALU_OR;
					XOR:     alu_op = ALU_XOR;
					SLT:     alu_op = ALU_SLT;
					default: known  = 1'b0;
				endcase
			end
			// address arithmetic for memory ops
			ADDI, LW, SW: alu_op = ALU_ADD;
			ANDI:         alu_op = ALU_AND;
			ORI:          alu_op = ALU_OR;
			XORI:         alu_op = ALU_XOR;
			LUI:          alu_op = ALU_LUI;
			default:      known  = 1'b0;
		endcase
	end

endmodule

// File: source/alu.sv
`timescale 1ns/10ps

module alu (
	input  mips_pkg::alu_op_t         op,
	input  logic [mips_pkg::XLEN-1:0] a,
	input  logic [mips_pkg::XLEN-1:0] b,
	output logic [mips_pkg::XLEN-1:0] y
);
	import mips_pkg::*;

	logic lt;

	// signed compare for slt
	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLT: y = {{(XLEN-1){1'b0}}, lt};
			// upper immediate, low half cleared
			ALU_LUI: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

// File: source/regfile.sv
`timescale 1ns/10ps

module regfile (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mips_pkg::REG_AW-1:0] ra1,
	input  logic [mips_pkg::REG_AW-1:0] ra2,
	input  logic                        we,
	input  logic [mips_pkg::REG_AW-1:0] wa,
	input  logic [mips_pkg::XLEN-1:0]   wd,
	output logic [mips_pkg::XLEN-1:0]   rd1,
	output logic [mips_pkg::XLEN-1:0]   rd2
);
	import mips_pkg::*;

	logic [XLEN-1:0] regs [2**REG_AW];

	// architectural state starts at zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// write-through covers the D/W overlap
	always_comb begin
		if (ra1 == '0)
			rd1 = '0;
		else if (we && (wa == ra1))
			rd1 = wd;
		else
			rd1 = regs[ra1];
		if (ra2 == '0)
			rd2 = '0;
		else if (we && (wa == ra2))
			rd2 = wd;
		else
			rd2 = regs[ra2];
	end

endmodule

// File: source/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mips_pkg::REG_AW-1:0] rs_d,
	input  logic [mips_pkg::REG_AW-1:0] rt_d,
	input  logic [mips_pkg::REG_AW-1:0] rs_e,
	input  logic [mips_pkg::REG_AW-1:0] rt_e,
	input  logic [mips_pkg::REG_AW-1:0] dst_e,
	input  logic                        mem_read_e,
	input  logic [mips_pkg::REG_AW-1:0] dst_m,
	input  logic                        reg_write_m,
	input  logic [mips_pkg::REG_AW-1:0] dst_w,
	input  logic                        reg_write_w,
	output logic                        stall_d,
	output logic                        flush_e,
	output mips_pkg::fwd_sel_t          fwd_a,
	output mips_pkg::fwd_sel_t          fwd_b
);
	import mips_pkg::*;

	logic load_use;

	// youngest producer wins
	function automatic fwd_sel_t pick_src(input logic [REG_AW-1:0] src);
		fwd_sel_t sel;
		sel = FWD_NONE;
		if (reg_write_m && (dst_m != '0) && (dst_m == src))
			sel = FWD_M;
		else if (reg_write_w && (dst_w != '0) && (dst_w == src))
			sel = FWD_W;
		return sel;
	endfunction

	// load in E feeding the instruction in D
	assign load_use = mem_read_e && (dst_e != '0) &&
		((dst_e == rs_d) || (dst_e == rt_d));

	assign stall_d = load_use;
	assign flush_e = load_use;

	assign fwd_a = pick_src(rs_e);
	assign fwd_b = pick_src(rt_e);

	// bubble in E must clear the stall on the next edge
	a_stall_single: assert property (@(posedge clk) disable iff (rst)
		stall_d |-> flush_e ##1 !stall_d)
		else $error("load-use stall held longer than one cycle");

endmodule

// File: source/main_decoder.sv
`timescale 1ns/10ps

module main_decoder (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mips_pkg::XLEN-1:0]   instr_d,
	input  logic                        valid_d,
	input  logic                        stall_d,
	input  logic                        flush_e,
	output logic [mips_pkg::REG_AW-1:0] rs_d,
	output logic [mips_pkg::REG_AW-1:0] rt_d,
	output logic                        mem_read_e,
	output logic                        reg_write_m,
	output logic [mips_pkg::REG_AW-1:0] dst_m,
	ctrl_if.decoder                     ctrl
);
	import mips_pkg::*;

	op_t               op;
	funct_t            funct;
	alu_op_t           alu_op_d;
	logic              known_d;
	logic              en_d;
	reg_dst_t          dst_sel_d;
	logic [REG_AW-1:0] dst_d;
	logic              reg_write_raw, alu_imm_sel_d, mem_read_raw, mem_write_raw, mem_to_reg_d;
	logic              reg_write_e, mem_write_e, mem_to_reg_e;
	logic              mem_write_m, mem_to_reg_m;

	assign op    = op_t'(instr_d[31:26]);
	assign funct = funct_t'(instr_d[5:0]);

	// bubbles present $0 as sources so they never match a load target
	assign rs_d = valid_d ? instr_d[25:21] : '0;
	assign rt_d = valid_d ? instr_d[20:16] : '0;

	alu_decoder u_alu_dec (
		.op     (op),
		.funct  (funct),
		.alu_op (alu_op_d),
		.known  (known_d)
	);

	always_comb begin
		reg_write_raw = 1'b0;
		dst_sel_d     = DST_RD;
		alu_imm_sel_d = 1'b0;
		mem_read_raw  = 1'b0;
		mem_write_raw = 1'b0;
		mem_to_reg_d  = 1'b0;
		case (op)
			R_TYPE: begin
				reg_write_raw = 1'b1;
			end
			ADDI, ANDI, ORI, XORI, LUI: begin
				reg_write_raw = 1'b1;
				dst_sel_d     = DST_RT;
				alu_imm_sel_d = 1'b1;
			end
			LW: begin
				reg_write_raw = 1'b1;
				dst_sel_d     = DST_RT;
				alu_imm_sel_d = 1'b1;
				mem_read_raw  = 1'b1;
				mem_to_reg_d  = 1'b1;
			end
			SW: begin
				alu_imm_sel_d = 1'b1;
				mem_write_raw = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign dst_d = (dst_sel_d == DST_RT) ? instr_d[20:16] : instr_d[15:11];
	// unknown encodings and empty slots behave as no-ops
	assign en_d  = valid_d && known_d;

	// D -> E, bubble on flush, hold on stall
	always_ff @(posedge clk) begin
		if (rst || flush_e) begin
			ctrl.alu_op_e      <= ALU_ADD;
			ctrl.alu_imm_sel_e <= 1'b0;
			ctrl.sign_ext_e    <= 1'b0;
			ctrl.dst_e         <= '0;
			reg_write_e        <= 1'b0;
			mem_read_e         <= 1'b0;
			mem_write_e        <= 1'b0;
			mem_to_reg_e       <= 1'b0;
		end else if (!stall_d) begin
			ctrl.alu_op_e      <= alu_op_d;
			ctrl.alu_imm_sel_e <= alu_imm_sel_d;
			// logical immediates zero-extend
			ctrl.sign_ext_e    <= !(op inside {ANDI, ORI, XORI});
			ctrl.dst_e         <= dst_d;
			reg_write_e        <= en_d && reg_write_raw && (dst_d != '0);
			mem_read_e         <= en_d && mem_read_raw;
			mem_write_e        <= en_d && mem_write_raw;
			mem_to_reg_e       <= mem_to_reg_d;
		end
	end

	// E -> M -> W
	always_ff @(posedge clk) begin
		if (rst) begin
			reg_write_m       <= 1'b0;
			dst_m             <= '0;
			ctrl.mem_read_m   <= 1'b0;
			mem_write_m       <= 1'b0;
			mem_to_reg_m      <= 1'b0;
			ctrl.reg_write_w  <= 1'b0;
			ctrl.dst_w        <= '0;
			ctrl.mem_to_reg_w <= 1'b0;
		end else begin
			reg_write_m       <= reg_write_e;
			dst_m             <= ctrl.dst_e;
			ctrl.mem_read_m   <= mem_read_e;
			mem_write_m       <= mem_write_e;
			mem_to_reg_m      <= mem_to_reg_e;
			ctrl.reg_write_w  <= reg_write_m;
			ctrl.dst_w        <= dst_m;
			ctrl.mem_to_reg_w <= mem_to_reg_m;
		end
	end

	assign ctrl.mem_write_m = mem_write_m;

	a_mem_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(ctrl.mem_read_m && ctrl.mem_write_m))
		else $error("load and store both active in M");

endmodule

// File: source/datapath.sv
`timescale 1ns/10ps

module datapath #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mips_pkg::XLEN-1:0]   instr,
	input  logic                        instr_valid,
	input  logic                        stall_d,
	input  mips_pkg::fwd_sel_t          fwd_a,
	input  mips_pkg::fwd_sel_t          fwd_b,
	output logic [mips_pkg::XLEN-1:0]   instr_d,
	output logic                        valid_d,
	output logic [mips_pkg::REG_AW-1:0] rs_e,
	output logic [mips_pkg::REG_AW-1:0] rt_e,
	output logic                        wb_en,
	output logic [mips_pkg::REG_AW-1:0] wb_addr,
	output logic [mips_pkg::XLEN-1:0]   wb_data,
	ctrl_if.datapath                    ctrl
);
	import mips_pkg::*;

	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	logic [XLEN-1:0]    rd1_d, rd2_d;
	logic [XLEN-1:0]    rd1_e, rd2_e;
	logic [15:0]        imm_e;
	logic [XLEN-1:0]    imm_ext_e, src_a_e, src_b_e, alu_b_e, alu_y_e;
	logic [XLEN-1:0]    alu_m, store_m, load_data_m;
	logic [DMEM_AW-1:0] addr_m;
	logic [XLEN-1:0]    alu_w, load_w;
	logic [XLEN-1:0]    dmem [DMEM_WORDS];

	function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_t sel,
		input logic [XLEN-1:0] reg_val, input logic [XLEN-1:0] m_val,
		input logic [XLEN-1:0] w_val);
		logic [XLEN-1:0] val;
		case (sel)
			FWD_M:   val = m_val;
			FWD_W:   val = w_val;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	// D register, a bubble when nothing is offered
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_d <= 1'b0;
		end else if (!stall_d) begin
			valid_d <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_d)
			instr_d <= instr;
	end

	regfile u_regfile (
		.clk (clk),
		.rst (rst),
		.ra1 (instr_d[25:21]),
		.ra2 (instr_d[20:16]),
		.we  (ctrl.reg_write_w),
		.wa  (ctrl.dst_w),
		.wd  (wb_data),
		.rd1 (rd1_d),
		.rd2 (rd2_d)
	);

	// D -> E operands
	always_ff @(posedge clk) begin
		rd1_e <= rd1_d;
		rd2_e <= rd2_d;
		imm_e <= instr_d[15:0];
		rs_e  <= instr_d[25:21];
		rt_e  <= instr_d[20:16];
	end

	assign imm_ext_e = ctrl.sign_ext_e ? {{(XLEN-16){imm_e[15]}}, imm_e} : {16'h0000, imm_e};
	assign src_a_e   = fwd_mux(fwd_a, rd1_e, alu_m, wb_data);
	assign src_b_e   = fwd_mux(fwd_b, rd2_e, alu_m, wb_data);
	assign alu_b_e   = ctrl.alu_imm_sel_e ? imm_ext_e : src_b_e;

	alu u_alu (
		.op (ctrl.alu_op_e),
		.a  (src_a_e),
		.b  (alu_b_e),
		.y  (alu_y_e)
	);

	// E -> M, store data is the forwarded rt
	always_ff @(posedge clk) begin
		alu_m   <= alu_y_e;
		store_m <= src_b_e;
	end

	// word index, wraps with the memory depth
	assign addr_m      = alu_m[DMEM_AW+1:2];
	assign load_data_m = dmem[addr_m];

	always_ff @(posedge clk) begin
		if (ctrl.mem_write_m)
			dmem[addr_m] <= store_m;
	end

	// M -> W
	always_ff @(posedge clk) begin
		alu_w <= alu_m;
		if (ctrl.mem_read_m)
			load_w <= load_data_m;
	end

	assign wb_en   = ctrl.reg_write_w;
	assign wb_addr = ctrl.dst_w;
	assign wb_data = ctrl.mem_to_reg_w ? load_w : alu_w;

	// $0 targets are dropped in decode
	a_no_wb_zero: assert property (@(posedge clk) disable iff (rst)
		wb_en |-> (wb_addr != '0))
		else $error("writeback to register 0");

endmodule

// File: source/mips_lite.sv
`timescale 1ns/10ps

module mips_lite #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [mips_pkg::XLEN-1:0]   instr,
	input  logic                        instr_valid,
	output logic                        stall,
	output logic                        wb_en,
	output logic [mips_pkg::REG_AW-1:0] wb_addr,
	output logic [mips_pkg::XLEN-1:0]   wb_data
);
	import mips_pkg::*;

	logic [XLEN-1:0]   instr_d;
	logic              valid_d;
	logic [REG_AW-1:0] rs_d, rt_d, rs_e, rt_e, dst_m;
	logic              mem_read_e, reg_write_m, flush_e;
	fwd_sel_t          fwd_a, fwd_b;

	ctrl_if u_ctrl ();

	main_decoder u_dec (
		.clk         (clk),
		.rst         (rst),
		.instr_d     (instr_d),
		.valid_d     (valid_d),
		.stall_d     (stall),
		.flush_e     (flush_e),
		.rs_d        (rs_d),
		.rt_d        (rt_d),
		.mem_read_e  (mem_read_e),
		.reg_write_m (reg_write_m),
		.dst_m       (dst_m),
		.ctrl        (u_ctrl.decoder)
	);

	hazard_unit u_haz (
		.clk         (clk),
		.rst         (rst),
		.rs_d        (rs_d),
		.rt_d        (rt_d),
		.rs_e        (rs_e),
		.rt_e        (rt_e),
		.dst_e       (u_ctrl.dst_e),
		.mem_read_e  (mem_read_e),
		.dst_m       (dst_m),
		.reg_write_m (reg_write_m),
		.dst_w       (u_ctrl.dst_w),
		.reg_write_w (u_ctrl.reg_write_w),
		.stall_d     (stall),
		.flush_e     (flush_e),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b)
	);

	datapath #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_dp (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall_d     (stall),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.instr_d     (instr_d),
		.valid_d     (valid_d),
		.rs_e        (rs_e),
		.rt_e        (rt_e),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.ctrl        (u_ctrl.datapath)
	);

endmodule

// File: sim/tb_mips_lite.sv
`timescale 1ns/10ps

module tb_mips_lite;
	import mips_pkg::*;

	localparam int DMEM_WORDS = 256;
	localparam int N_RANDOM   = 600;

	logic              clk;
	logic              rst;
	logic [XLEN-1:0]   instr;
	logic              instr_valid;
	logic              stall;
	logic              wb_en;
	logic [REG_AW-1:0] wb_addr;
	logic [XLEN-1:0]   wb_data;

	integer            seed;
	int                model_count;
	int                wb_count;
	int                stall_count;
	logic [XLEN-1:0]   m_regs [32];
	logic [XLEN-1:0]   m_mem [DMEM_WORDS];
	logic [REG_AW-1:0] exp_addr_q [$];
	logic [XLEN-1:0]   exp_data_q [$];

	// shadow of D and E for the load-use rule
	logic              d_valid;
	logic [XLEN-1:0]   d_word;
	logic              e_load;
	logic [REG_AW-1:0] e_dst;

	mips_lite #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_dut (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic end_in_failure();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_failure(input string why);
		$display("[ERROR] t=%0t %s", $time, why);
		end_in_failure();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			end_in_failure();
		end
	endtask

	function automatic logic [31:0] encode_r(input funct_t fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {R_TYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encode_i(input op_t op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// architectural model executing one accepted instruction at a time
	task automatic execute_model(input logic [31:0] w);
		logic [4:0]  dst;
		logic [31:0] a, b, sx, zx, val, addr;
		logic        wr;
		a    = m_regs[w[25:21]];
		b    = m_regs[w[20:16]];
		sx   = {{16{w[15]}}, w[15:0]};
		zx   = {16'h0000, w[15:0]};
		addr = a + sx;
		dst  = w[20:16];
		val  = '0;
		wr   = 1'b1;
		case (op_t'(w[31:26]))
			R_TYPE: begin
				dst = w[15:11];
				case (funct_t'(w[5:0]))
					ADDU:    val = a + b;
					SUBU:    val = a - b;
					AND:     val = a & b;
					OR:      val = a | b;
					XOR:     val = a ^ b;
					SLT:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			ADDI: val = a + sx;
			ANDI: val = a & zx;
			ORI:  val = a | zx;
			XORI: val = a ^ zx;
			LUI:  val = {w[15:0], 16'h0000};
			LW:   val = m_mem[(addr >> 2) % DMEM_WORDS];
			SW: begin
				m_mem[(addr >> 2) % DMEM_WORDS] = b;
				wr = 1'b0;
			end
			default: wr = 1'b0;
		endcase
		if (wr && (dst != 5'd0)) begin
			m_regs[dst] = val;
			exp_addr_q.push_back(dst);
			exp_data_q.push_back(val);
			model_count++;
		end
	endtask

	// one cycle of stimulus with stall checked against the load-use rule
	task automatic drive_cycle(input logic v, input logic [31:0] word, output logic acc);
		logic exp_stall;
		@(negedge clk);
		instr       = word;
		instr_valid = v;
		exp_stall   = e_load && (e_dst != 5'd0) && d_valid &&
			((e_dst == d_word[25:21]) || (e_dst == d_word[20:16]));
		check_value("stall", {31'b0, stall}, {31'b0, exp_stall});
		acc = v && !stall;
		if (acc)
			execute_model(word);
		if (exp_stall) begin
			stall_count++;
			e_load = 1'b0;
			e_dst  = '0;
		end else begin
			e_load  = d_valid && (op_t'(d_word[31:26]) == LW);
			e_dst   = d_word[20:16];
			d_valid = v;
			d_word  = word;
		end
	endtask

	task automatic issue(input logic [31:0] word);
		int   tries;
		logic acc;
		tries = 0;
		acc   = 1'b0;
		while (!acc && (tries < 2)) begin
			drive_cycle(1'b1, word, acc);
			tries++;
		end
		if (!acc)
			report_failure("instruction not accepted within two cycles");
	endtask

	task automatic idle_cycle();
		logic acc;
		drive_cycle(1'b0, $random(seed), acc);
	endtask

	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [4:0]  rs, rt, rd;
		logic [15:0] waddr;
		r     = $random(seed);
		rs    = {2'b00, r[6:4]};
		rt    = {2'b00, r[9:7]};
		rd    = {2'b00, r[12:10]};
		waddr = {10'd0, r[19:16], 2'b00};
		case (r[3:0])
			4'd0:  return encode_r(ADDU, rd, rs, rt);
			4'd1:  return encode_r(SUBU, rd, rs, rt);
			4'd2:  return encode_r(AND, rd, rs, rt);
			4'd3:  return encode_r(OR, rd, rs, rt);
			4'd4:  return encode_r(XOR, rd, rs, rt);
			4'd5:  return encode_r(SLT, rd, rs, rt);
			4'd6:  return encode_i(ADDI, rt, rs, r[31:16]);
			4'd7:  return encode_i(ANDI, rt, rs, r[31:16]);
			4'd8:  return encode_i(ORI, rt, rs, r[31:16]);
			4'd9:  return encode_i(XORI, rt, rs, r[31:16]);
			4'd10: return encode_i(LUI, rt, 5'd0, r[31:16]);
			4'd11, 4'd12: return encode_i(LW, rt, 5'd0, waddr);
			// bad opcode or bad funct
			4'd14: return r[13] ? {6'h3f, r[25:0]} : {6'h00, rs, rt, rd, 5'd0, 6'h00};
			default: return encode_i(SW, rt, 5'd0, waddr);
		endcase
	endfunction

	// writeback monitor sampled mid-cycle
	always @(negedge clk) begin
		if (wb_en !== 1'b0) begin
			if (exp_data_q.size() == 0) begin
				report_failure("writeback seen with no result expected");
			end else begin
				check_value("wb_addr", {27'b0, wb_addr}, {27'b0, exp_addr_q.pop_front()});
				check_value("wb_data", wb_data, exp_data_q.pop_front());
				wb_count++;
			end
		end
	end

	initial begin
		logic [31:0] r;
		seed        = 32'h4749;
		rst         = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		model_count = 0;
		wb_count    = 0;
		stall_count = 0;
		d_valid     = 1'b0;
		d_word      = '0;
		e_load      = 1'b0;
		e_dst       = '0;
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			m_mem[i] = '0;
		for (int i = 0; i < 8; i++)
			@(negedge clk);
		rst = 1'b0;

		// full 32-bit register values from lui then ori through M forwarding
		for (int i = 1; i < 8; i++) begin
			r = $random(seed);
			issue(encode_i(LUI, 5'(i), 5'd0, r[31:16]));
			issue(encode_i(ORI, 5'(i), 5'(i), r[15:0]));
		end
		// fill the load window so no load reads an unwritten word
		for (int w = 0; w < 16; w++)
			issue(encode_i(SW, 5'(1 + w % 7), 5'd0, 16'(w * 4)));

		// load-use then sign versus zero extension and slt
		issue(encode_i(LW, 5'd1, 5'd0, 16'd4));
		issue(encode_r(ADDU, 5'd2, 5'd1, 5'd1));
		issue(encode_i(ADDI, 5'd3, 5'd0, 16'hfffb));
		issue(encode_r(SLT, 5'd4, 5'd3, 5'd0));
		issue(encode_r(SUBU, 5'd5, 5'd4, 5'd3));
		issue(encode_i(ANDI, 5'd7, 5'd3, 16'h8001));
		idle_cycle();
		issue(encode_r(XOR, 5'd6, 5'd5, 5'd3));
		// store then load from the same word
		issue(encode_i(SW, 5'd5, 5'd0, 16'd8));
		idle_cycle();
		issue(encode_i(LW, 5'd6, 5'd0, 16'd8));
		// no writeback expected for these
		issue(encode_i(ADDI, 5'd0, 5'd0, 16'd7));
		issue(32'hfc00_0000);
		issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h00});

		for (int n = 0; n < N_RANDOM; n++) begin
			r = $random(seed);
			if (r[2:0] == 3'd0)
				idle_cycle();
			else
				issue(random_instr());
		end

		for (int i = 0; i < 10; i++)
			idle_cycle();

		if (exp_data_q.size() != 0) begin
			report_failure("expected writebacks still pending after drain");
		end else if (wb_count != model_count) begin
			report_failure("writeback count differs from the model count");
		end else begin
			$display("writebacks %0d, load-use stalls %0d", wb_count, stall_count);
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

// File: mips_lite.f
source/mips_pkg.sv
source/ctrl_if.sv
source/alu_decoder.sv
source/alu.sv
source/regfile.sv
source/hazard_unit.sv
source/main_decoder.sv
source/datapath.sv
source/mips_lite.sv
sim/tb_mips_lite.sv
